// ==== Bender.yml ====
package:
  name: xotr_unit

sources:
  - include_dirs:
      - source
    files:
      - source/xotrPkg.sv
      - source/imDecoder.sv
      - source/transferDecoder.sv
      - source/xotrDecoder.sv
      - source/xotrControl.sv
      - source/xotrUnit.sv
  - target: test
    include_dirs:
      - source
      - verif
    files:
      - verif/xotrTb.sv

// ==== compile.f ====
+incdir+source
+incdir+verif
source/xotrPkg.sv
source/imDecoder.sv
source/transferDecoder.sv
source/xotrDecoder.sv
source/xotrControl.sv
source/xotrUnit.sv
verif/xotrTb.sv

// ==== source/imDecoder.sv ====
// Step decoder for the IM 0/1/2 opcodes (01xxx110), instantiated by xotrDecoder
`timescale 1ns/1ns

module imDecoder import xotrPkg::*; (
    input  logic     enable,
    input  xptStep_t xpt,
    input  opcode_t  source,
    output logic     PR_Reset_XPT,
    output logic     P2_Set_CM1,
    output logic     P2_Reset_XOTR,
    output logic     Pa_Ophd,
    output logic     P2_IM0,
    output logic     P2_IM1,
    output logic     P2_IM2
);

    logic firstStep;

    // Single step instructions
    assign firstStep = enable && (xpt == '0);

    // 00 and 01 both select mode 0
    assign P2_IM0 = firstStep && !source[4];
    assign P2_IM1 = firstStep && (source[4:3] == 2'b10);
    assign P2_IM2 = firstStep && (source[4:3] == 2'b11);

    assign PR_Reset_XPT  = firstStep; // End group
    assign P2_Set_CM1    = firstStep;
    assign P2_Reset_XOTR = firstStep;
    assign Pa_Ophd       = firstStep;

    // Mode opcodes end in step 0, the sequencer must never run past it
    imStepCheck: assert final (!enable || (xpt == '0));

endmodule

// ==== source/transferDecoder.sv ====
// Step decoder for LD I/R/A, RRD, RLD and the NOP slots (01xxx111), used by xotrDecoder
`timescale 1ns/1ns

module transferDecoder import xotrPkg::*; (
    input  logic     enable,
    input  xptStep_t xpt,
    input  opcode_t  source,
    output logic     PR_Reset_XPT,
    output logic     P2_Set_CM1,
    output logic     P2_Reset_XOTR,
    output logic     Pa_Ophd,
    output logic     PA_Select_A_low,
    output logic     PA_NOP,
    output logic     PR_Write_I,
    output logic     PR_InvertIn,
    output logic     PR_Write_R,
    output logic     PR_Write_A,
    output logic     PF_Write_Z,
    output logic     PF_Write_PV,
    output logic     PF_Write_S,
    output logic     PF_Write_N,
    output logic     PF_Write_H,
    output logic     PF_Select_S_bit7,
    output logic     PF_Select_N_bit16,
    output logic     PF_Select_H_bit16,
    output logic     PF_Select_Z_bit19,
    output logic     PF_Select_PV_bit18,
    output logic     PA_Select_I_low,
    output logic     PA_Select_R_low,
    output logic     PC_R0,
    output logic     PC_R1,
    output logic     PC_R2,
    output logic     PR_Write_Dt,
    output logic     PA_Select_Dt_high,
    output logic     PF_Select_Z_bit24,
    output logic     PF_Select_PV_bit27,
    output logic     PC_W0,
    output logic     PC_W1,
    output logic     PC_W2,
    output logic     PI_SelectDt_Dt,
    output logic     PI_SelectAd_HL,
    output logic     PA_RRD,
    output logic     PA_RLD
);

    logic [2:0] op;
    logic [5:0] atStep;
    logic       ldToSpecial;
    logic       ldFromSpecial;
    logic       rotate;
    logic       nop;
    logic       flagLoad;
    logic       flagRotate;
    logic       lastStep;

    assign op = source[5:3];

    // One line per step, all low while disabled
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            atStep[i] = enable && (xpt == xptStep_t'(i));
        end
    end

    assign ldToSpecial   = (op[2:1] == 2'b00); // LD I,A and LD R,A
    assign ldFromSpecial = (op[2:1] == 2'b01); // LD A,I and LD A,R
    assign rotate        = (op[2:1] == 2'b10); // RRD, RLD
    assign nop           = (op[2:1] == 2'b11);

    assign PA_Select_A_low = atStep[0] && ldToSpecial;
    assign PR_Write_I      = atStep[0] && ldToSpecial && !op[0];
    assign PR_Write_R      = atStep[0] && ldToSpecial && op[0];
    assign PA_Select_I_low = atStep[0] && ldFromSpecial && !op[0];
    assign PA_Select_R_low = atStep[0] && ldFromSpecial && op[0];
    assign PA_NOP          = atStep[0] && nop;
    assign PR_InvertIn     = 1'b0; // Never needed in this group

    // Memory read of (HL) into the temp register
    assign PI_SelectAd_HL = atStep[0] && rotate;
    assign PC_R0          = atStep[0] && rotate;
    assign PC_R1          = atStep[1] && rotate;
    assign PC_R2          = atStep[2] && rotate;
    assign PR_Write_Dt    = atStep[2] && rotate;
    assign PI_SelectDt_Dt = atStep[2] && rotate;

    // Nibble swap, then write back
    assign PA_RRD            = atStep[3] && rotate && !op[0];
    assign PA_RLD            = atStep[3] && rotate && op[0];
    assign PA_Select_Dt_high = atStep[3] && rotate;
    assign PC_W0             = atStep[3] && rotate;
    assign PC_W1             = atStep[4] && rotate;
    assign PC_W2             = atStep[5] && rotate;

    assign PR_Write_A = (atStep[0] && ldFromSpecial) || (atStep[3] && rotate);

    assign flagLoad   = atStep[0] && ldFromSpecial;
    assign flagRotate = atStep[5] && rotate;

    assign PF_Write_Z       = flagLoad || flagRotate;
    assign PF_Write_PV      = flagLoad || flagRotate;
    assign PF_Write_S       = flagLoad || flagRotate;
    assign PF_Write_N       = flagLoad || flagRotate;
    assign PF_Write_H       = flagLoad || flagRotate;
    assign PF_Select_S_bit7 = flagLoad || flagRotate;

    // PV from IFF2 on LD A,I/R
    assign PF_Select_Z_bit19  = flagLoad;
    assign PF_Select_PV_bit18 = flagLoad;
    assign PF_Select_N_bit16  = flagLoad;
    assign PF_Select_H_bit16  = flagLoad;
    assign PF_Select_Z_bit24  = flagRotate;
    assign PF_Select_PV_bit27 = flagRotate;

    assign lastStep = rotate ? atStep[5] : atStep[0];

    assign PR_Reset_XPT  = lastStep;
    assign P2_Set_CM1    = lastStep;
    assign P2_Reset_XOTR = lastStep;
    assign Pa_Ophd       = lastStep;

    // Sequencer stops at the last step, so no step beyond it ever comes here
    stepRangeCheck: assert final (!enable || (xpt <= (rotate ? 5 : 0)));

endmodule

// ==== source/xotrControl.sv ====
// Opcode latch, step counter and interrupt mode register for the 01xxx11x group
`timescale 1ns/1ns

`include "xotr_settings.svh"

module xotrControl import xotrPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  opcode_t  opcode,
    input  logic     endXpt,
    input  logic     P2_IM0,
    input  logic     P2_IM1,
    input  logic     P2_IM2,
    output logic     enable,
    output logic     busy,
    output logic     done,
    output logic     rejected,
    output opcode_t  source,
    output xptStep_t xpt,
    output intMode_t intMode
);

    logic inGroup;
    logic accept;

    // 01xxx11x only
    assign inGroup = (opcode[7:6] == 2'b01) && (opcode[2:1] == 2'b11);
    assign accept  = start && !busy;

    assign enable = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            rejected <= 1'b0;
            xpt      <= '0;
        end else begin
            done     <= busy && endXpt;
            rejected <= accept && !inGroup;
            if (busy) begin
                if (endXpt) begin
                    busy <= 1'b0;
                    xpt  <= '0;
                end else begin
                    xpt <= xpt + 1'b1;
                end
            end else if (accept && inGroup) begin
                busy <= 1'b1; // Step 0 next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && inGroup) begin
            source <= opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            intMode <= IM0;
        end else if (P2_IM2) begin
            intMode <= IM2;
        end else if (P2_IM1) begin
            intMode <= IM1;
        end else if (P2_IM0) begin
            intMode <= IM0;
        end
    end

    // Decoder must end every instruction before the counter runs past the longest one
    stepLimit: assert property (@(posedge clk) disable iff (rst)
        xpt < `XOTR_MAX_STEPS);

endmodule

// ==== source/xotrDecoder.sv ====
// Decoder for the whole 01xxx11x group, splits on bit 0 and merges the end strobes
`timescale 1ns/1ns

module xotrDecoder import xotrPkg::*; (
    input  logic     enable,
    input  xptStep_t xpt,
    input  opcode_t  source,
    output logic     PR_Reset_XPT,
    output logic     P2_Set_CM1,
    output logic     P2_Reset_XOTR,
    output logic     Pa_Ophd,
    output logic     P2_IM0,
    output logic     P2_IM1,
    output logic     P2_IM2,
    output logic     PA_Select_A_low,
    output logic     PA_NOP,
    output logic     PR_Write_I,
    output logic     PR_InvertIn,
    output logic     PR_Write_R,
    output logic     PR_Write_A,
    output logic     PF_Write_Z,
    output logic     PF_Write_PV,
    output logic     PF_Write_S,
    output logic     PF_Write_N,
    output logic     PF_Write_H,
    output logic     PF_Select_S_bit7,
    output logic     PF_Select_N_bit16,
    output logic     PF_Select_H_bit16,
    output logic     PF_Select_Z_bit19,
    output logic     PF_Select_PV_bit18,
    output logic     PA_Select_I_low,
    output logic     PA_Select_R_low,
    output logic     PC_R0,
    output logic     PC_R1,
    output logic     PC_R2,
    output logic     PR_Write_Dt,
    output logic     PA_Select_Dt_high,
    output logic     PF_Select_Z_bit24,
    output logic     PF_Select_PV_bit27,
    output logic     PC_W0,
    output logic     PC_W1,
    output logic     PC_W2,
    output logic     PI_SelectDt_Dt,
    output logic     PI_SelectAd_HL,
    output logic     PA_RRD,
    output logic     PA_RLD
);

    logic       imEnable;
    logic       transferEnable;
    logic [3:0] imEnd;
    logic [3:0] transferEnd;

    // Bit 0 picks 01xxx110 or 01xxx111
    assign imEnable       = enable && !source[0];
    assign transferEnable = enable && source[0];

    imDecoder uIm (
        .enable        (imEnable),
        .PR_Reset_XPT  (imEnd[0]),
        .P2_Set_CM1    (imEnd[1]),
        .P2_Reset_XOTR (imEnd[2]),
        .Pa_Ophd       (imEnd[3]),
        .*
    );

    transferDecoder uTransfer (
        .enable        (transferEnable),
        .PR_Reset_XPT  (transferEnd[0]),
        .P2_Set_CM1    (transferEnd[1]),
        .P2_Reset_XOTR (transferEnd[2]),
        .Pa_Ophd       (transferEnd[3]),
        .*
    );

    assign PR_Reset_XPT  = (|imEnd) || (|transferEnd);
    assign P2_Set_CM1    = PR_Reset_XPT;
    assign P2_Reset_XOTR = PR_Reset_XPT;
    assign Pa_Ophd       = PR_Reset_XPT;

endmodule

// ==== source/xotrPkg.sv ====
// Opcode, step and interrupt mode types, imported by the 01xxx11x RTL and its testbench
package xotrPkg;

`include "xotr_settings.svh"

    // Opcode byte that follows the extended prefix
    typedef logic [`XOTR_OPCODE_WIDTH-1:0] opcode_t;

    // Step within the running instruction, 0 is the first
    typedef logic [`XOTR_STEP_WIDTH-1:0] xptStep_t;

    // Interrupt mode as set by IM 0, IM 1 and IM 2
    typedef enum logic [1:0] {
        IM0 = 2'd0,
        IM1 = 2'd1,
        IM2 = 2'd2
    } intMode_t;

endpackage

// ==== source/xotrUnit.sv ====
// Top level of the 01xxx11x execution decoder, connects the sequencer to the group decoder
`timescale 1ns/1ns

module xotrUnit import xotrPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  opcode_t  opcode,
    output logic     busy,
    output logic     done,
    output logic     rejected,
    output intMode_t intMode,
    output logic     PR_Reset_XPT,
    output logic     P2_Set_CM1,
    output logic     P2_Reset_XOTR,
    output logic     Pa_Ophd,
    output logic     P2_IM0,
    output logic     P2_IM1,
    output logic     P2_IM2,
    output logic     PA_Select_A_low,
    output logic     PA_NOP,
    output logic     PR_Write_I,
    output logic     PR_InvertIn,
    output logic     PR_Write_R,
    output logic     PR_Write_A,
    output logic     PF_Write_Z,
    output logic     PF_Write_PV,
    output logic     PF_Write_S,
    output logic     PF_Write_N,
    output logic     PF_Write_H,
    output logic     PF_Select_S_bit7,
    output logic     PF_Select_N_bit16,
    output logic     PF_Select_H_bit16,
    output logic     PF_Select_Z_bit19,
    output logic     PF_Select_PV_bit18,
    output logic     PA_Select_I_low,
    output logic     PA_Select_R_low,
    output logic     PC_R0,
    output logic     PC_R1,
    output logic     PC_R2,
    output logic     PR_Write_Dt,
    output logic     PA_Select_Dt_high,
    output logic     PF_Select_Z_bit24,
    output logic     PF_Select_PV_bit27,
    output logic     PC_W0,
    output logic     PC_W1,
    output logic     PC_W2,
    output logic     PI_SelectDt_Dt,
    output logic     PI_SelectAd_HL,
    output logic     PA_RRD,
    output logic     PA_RLD
);

    logic     enable;
    opcode_t  source;
    xptStep_t xpt;

    xotrControl uControl (
        .endXpt (PR_Reset_XPT),
        .*
    );

    // Strobes go straight out by name
    xotrDecoder uDecoder (
        .*
    );

endmodule

// ==== source/xotr_settings.svh ====
// Width and step limit macros for the 01xxx11x decoder, included by the package and RTL
`ifndef XOTR_SETTINGS_SVH
`define XOTR_SETTINGS_SVH

// Step number width, matches the CPU step counter
`define XOTR_STEP_WIDTH 5

// Second byte after the extended prefix
`define XOTR_OPCODE_WIDTH 8

// RRD and RLD are the longest at six steps
`define XOTR_MAX_STEPS 6

`endif

// ==== verif/xotrModel.svh ====
// Reference model of the 01xxx11x group, included inside the testbench module body
`ifndef XOTR_MODEL_SVH
`define XOTR_MODEL_SVH

// Same order as the strobe concatenation in the testbench
typedef struct packed {
    logic PR_Reset_XPT, P2_Set_CM1, P2_Reset_XOTR, Pa_Ophd;
    logic P2_IM0, P2_IM1, P2_IM2;
    logic PA_Select_A_low, PA_NOP, PR_Write_I, PR_InvertIn, PR_Write_R, PR_Write_A;
    logic PF_Write_Z, PF_Write_PV, PF_Write_S, PF_Write_N, PF_Write_H;
    logic PF_Select_S_bit7, PF_Select_N_bit16, PF_Select_H_bit16;
    logic PF_Select_Z_bit19, PF_Select_PV_bit18;
    logic PA_Select_I_low, PA_Select_R_low;
    logic PC_R0, PC_R1, PC_R2;
    logic PR_Write_Dt, PA_Select_Dt_high;
    logic PF_Select_Z_bit24, PF_Select_PV_bit27;
    logic PC_W0, PC_W1, PC_W2;
    logic PI_SelectDt_Dt, PI_SelectAd_HL, PA_RRD, PA_RLD;
} strobeSet_t;

function automatic logic isGroupOpcode(input opcode_t op);
    return (op[7:6] == 2'b01) && (op[2:1] == 2'b11);
endfunction

// RRD and RLD take six steps, everything else one
function automatic int instrLength(input opcode_t op);
    return (op[0] && (op[5:4] == 2'b10)) ? 6 : 1;
endfunction

function automatic intMode_t nextMode(input opcode_t op, input intMode_t current);
    if (!isGroupOpcode(op) || op[0]) begin
        return current;
    end
    case (op[4:3])
        2'b10:   return IM1;
        2'b11:   return IM2;
        default: return IM0;
    endcase
endfunction

function automatic strobeSet_t expectedStrobes(input opcode_t op, input int step);
    strobeSet_t s;
    logic lastStep;
    s = '0;
    lastStep = isGroupOpcode(op) && (step == instrLength(op) - 1);
    if (isGroupOpcode(op) && !op[0] && step == 0) begin
        case (op[4:3])
            2'b10:   s.P2_IM1 = 1'b1;
            2'b11:   s.P2_IM2 = 1'b1;
            default: s.P2_IM0 = 1'b1;
        endcase
    end else if (isGroupOpcode(op) && op[0]) begin
        case (op[5:3])
            3'b000, 3'b001: begin
                s.PA_Select_A_low = (step == 0);
                s.PR_Write_I      = (step == 0) && !op[3];
                s.PR_Write_R      = (step == 0) && op[3];
            end
            3'b010, 3'b011: if (step == 0) begin
                s.PA_Select_I_low = !op[3];
                s.PA_Select_R_low = op[3];
                s.PR_Write_A      = 1'b1;
                {s.PF_Write_Z, s.PF_Write_PV, s.PF_Write_S, s.PF_Write_N, s.PF_Write_H} = '1;
                {s.PF_Select_S_bit7, s.PF_Select_Z_bit19, s.PF_Select_PV_bit18} = '1;
                {s.PF_Select_N_bit16, s.PF_Select_H_bit16} = '1;
            end
            3'b100, 3'b101: case (step)
                0: {s.PI_SelectAd_HL, s.PC_R0} = '1;
                1: s.PC_R1 = 1'b1;
                2: {s.PC_R2, s.PR_Write_Dt, s.PI_SelectDt_Dt} = '1;
                3: begin
                    s.PA_RRD = !op[3];
                    s.PA_RLD = op[3];
                    {s.PA_Select_Dt_high, s.PR_Write_A, s.PC_W0} = '1;
                end
                4: s.PC_W1 = 1'b1;
                5: begin
                    s.PC_W2 = 1'b1;
                    {s.PF_Write_Z, s.PF_Write_PV, s.PF_Write_S, s.PF_Write_N, s.PF_Write_H} = '1;
                    {s.PF_Select_Z_bit24, s.PF_Select_PV_bit27, s.PF_Select_S_bit7} = '1;
                end
                default: ;
            endcase
            default: s.PA_NOP = (step == 0);
        endcase
    end
    // End group in the last step of every opcode
    {s.PR_Reset_XPT, s.P2_Set_CM1, s.P2_Reset_XOTR, s.Pa_Ophd} = {4{lastStep}};
    return s;
endfunction

`endif

// ==== verif/xotrTb.sv ====
// Testbench for xotrUnit, runs directed and random opcodes and compares every cycle with a model
`timescale 1ns/1ns

module xotrTb import xotrPkg::*; ();

`include "xotrModel.svh"

    localparam int numIssued  = 237; // 8 IM, 8 transfer, 20 rejects, busy test, 200 mixed
    localparam int cycleLimit = 8 * numIssued + 50;

    logic     clk;
    logic     rst;
    logic     start;
    opcode_t  opcode;
    logic     busy;
    logic     done;
    logic     rejected;
    intMode_t intMode;
    logic     PR_Reset_XPT, P2_Set_CM1, P2_Reset_XOTR, Pa_Ophd;
    logic     P2_IM0, P2_IM1, P2_IM2;
    logic     PA_Select_A_low, PA_NOP, PR_Write_I, PR_InvertIn, PR_Write_R, PR_Write_A;
    logic     PF_Write_Z, PF_Write_PV, PF_Write_S, PF_Write_N, PF_Write_H;
    logic     PF_Select_S_bit7, PF_Select_N_bit16, PF_Select_H_bit16;
    logic     PF_Select_Z_bit19, PF_Select_PV_bit18;
    logic     PA_Select_I_low, PA_Select_R_low;
    logic     PC_R0, PC_R1, PC_R2;
    logic     PR_Write_Dt, PA_Select_Dt_high;
    logic     PF_Select_Z_bit24, PF_Select_PV_bit27;
    logic     PC_W0, PC_W1, PC_W2;
    logic     PI_SelectDt_Dt, PI_SelectAd_HL, PA_RRD, PA_RLD;

    strobeSet_t dutStrobes;
    int         errorCount = 0;
    int         checkCount = 0;
    integer     seed;

    // Model state, advanced by the compare process
    logic     expActive;
    opcode_t  expOpcode;
    int       expStep;
    intMode_t expMode;
    logic     expDone;
    logic     expRejected;

    xotrUnit DUT (.*);

    assign dutStrobes = {PR_Reset_XPT, P2_Set_CM1, P2_Reset_XOTR, Pa_Ophd,
        P2_IM0, P2_IM1, P2_IM2,
        PA_Select_A_low, PA_NOP, PR_Write_I, PR_InvertIn, PR_Write_R, PR_Write_A,
        PF_Write_Z, PF_Write_PV, PF_Write_S, PF_Write_N, PF_Write_H,
        PF_Select_S_bit7, PF_Select_N_bit16, PF_Select_H_bit16,
        PF_Select_Z_bit19, PF_Select_PV_bit18, PA_Select_I_low, PA_Select_R_low,
        PC_R0, PC_R1, PC_R2, PR_Write_Dt, PA_Select_Dt_high,
        PF_Select_Z_bit24, PF_Select_PV_bit27, PC_W0, PC_W1, PC_W2,
        PI_SelectDt_Dt, PI_SelectAd_HL, PA_RRD, PA_RLD};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Sampled on the rising edge, before the DUT registers update
    always @(posedge clk) begin : compare
        logic lastStep;
        if (rst) begin
            expActive   = 1'b0;
            expStep     = 0;
            expMode     = IM0;
            expDone     = 1'b0;
            expRejected = 1'b0;
        end else begin
            checkValue(busy, expActive, "busy");
            checkValue(done, expDone, "done");
            checkValue(rejected, expRejected, "rejected");
            checkValue(intMode, expMode, "intMode");
            if (expActive) begin
                checkValue(dutStrobes, expectedStrobes(expOpcode, expStep),
                    $sformatf("strobes for opcode %h step %0d", expOpcode, expStep));
            end else begin
                checkValue(dutStrobes, '0, "strobes while idle");
            end
            lastStep    = expActive && (expStep == instrLength(expOpcode) - 1);
            expDone     = lastStep;
            expRejected = start && !expActive && !isGroupOpcode(opcode);
            if (expActive) begin
                expStep++;
                if (lastStep) begin
                    expActive = 1'b0;
                    expMode   = nextMode(expOpcode, expMode);
                end
            end else if (start && isGroupOpcode(opcode)) begin
                expActive = 1'b1;
                expOpcode = opcode;
                expStep   = 0;
            end
        end
    end

    task automatic waitForEnd(input opcode_t op);
        int waitCycles;
        waitCycles = 0;
        while (!done && !rejected && waitCycles < 10) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!done && !rejected) begin
            errorCount++;
            $display("Opcode %h never finished, neither done nor rejected came", op);
        end
    endtask

    task automatic runOpcode(input opcode_t op);
        @(negedge clk);
        start  = 1'b1;
        opcode = op;
        @(negedge clk);
        start = 1'b0;
        waitForEnd(op);
    endtask

    initial begin : stimulus
        opcode_t     op;
        logic [31:0] r;
        seed   = 32'h20b1_f94f;
        rst    = 1'b1;
        start  = 1'b0;
        opcode = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue({busy, done, rejected}, '0, "control outputs after reset");
        checkValue(dutStrobes, '0, "strobes after reset");
        checkValue(intMode, IM0, "intMode after reset");
        for (int i = 0; i < 8; i++) begin
            runOpcode(opcode_t'(8'h46 + 8 * i)); // IM and aliases
        end
        runOpcode(8'h47);
        runOpcode(8'h4F);
        runOpcode(8'h57);
        runOpcode(8'h5F);
        runOpcode(8'h77);
        runOpcode(8'h7F);
        runOpcode(8'h67); // RRD
        runOpcode(8'h6F); // RLD
        for (int i = 0; i < 20; i++) begin
            op = opcode_t'($random(seed));
            while (isGroupOpcode(op)) op = opcode_t'($random(seed));
            runOpcode(op);
        end
        // Second start held while busy must be ignored
        @(negedge clk);
        start  = 1'b1;
        opcode = 8'h6F;
        @(negedge clk);
        opcode = 8'h5E;
        @(negedge clk);
        start = 1'b0;
        waitForEnd(8'h6F);
        for (int i = 0; i < 200; i++) begin
            r  = $random(seed);
            op = (r[9:8] == 2'b00) ? r[7:0] : {2'b01, r[5:3], 2'b11, r[0]};
            runOpcode(op);
        end
        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not reach its end", cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule
